// ==== files.f ====
mips_isa_pkg.sv
issue_pkg.sv
inst_queue.sv
inst_decoder.sv
issue_ctrl.sv
exec_stage_reg.sv
dual_issue_stage.sv
dual_issue_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator and run it, the exit status reports the result
verilator --binary --timing --timescale 1ns/10ps -f files.f \
    --top-module dual_issue_tb -o dual_issue_tb \
    && ./obj_dir/dual_issue_tb \
    || { echo "run_sim: build or simulation failed"; exit 1; }

// ==== dual_issue_tb.sv ====
`timescale 1ns/10ps

module dual_issue_tb;

    localparam int depth      = issue_pkg::QUEUE_DEPTH_DEFAULT;
    localparam int run_cycles = 3000;

    typedef struct packed {
        logic                    wen;
        mips_isa_pkg::reg_addr_t waddr;
        logic                    mem;
        logic                    load;
        logic                    branch;
        logic                    spec;
        logic                    master_only;
    } dec_t;

    logic                clk         = 1'b0;
    logic                rst         = 1'b1;
    logic                fetch_push  = 1'b0;
    mips_isa_pkg::inst_t fetch_inst0 = '0;
    mips_isa_pkg::inst_t fetch_inst1 = '0;
    issue_pkg::pc_t      fetch_pc    = '0;
    logic                stall       = 1'b0;

    logic                queue_full;
    logic                issue_master_valid;
    mips_isa_pkg::inst_t issue_master_inst;
    issue_pkg::pc_t      issue_master_pc;
    logic                issue_slave_valid;
    mips_isa_pkg::inst_t issue_slave_inst;
    issue_pkg::pc_t      issue_slave_pc;
    logic                slave_in_delayslot;

    mips_isa_pkg::inst_t     q_inst[$];  // model queue, head at index 0.
    issue_pkg::pc_t          q_pc[$];
    logic                    em_load  = 1'b0;
    mips_isa_pkg::reg_addr_t em_waddr = '0;
    logic                    es_load  = 1'b0;
    mips_isa_pkg::reg_addr_t es_waddr = '0;
    issue_pkg::pc_t          next_fetch_pc = 32'hbfc0_0000;
    integer                  seed = 83;

    dual_issue_stage #(.queue_depth(depth)) i_dual_issue_stage (
        .clk(clk), .rst(rst), .fetch_push(fetch_push), .fetch_inst0(fetch_inst0),
        .fetch_inst1(fetch_inst1), .fetch_pc(fetch_pc), .stall(stall),
        .queue_full(queue_full), .issue_master_valid(issue_master_valid),
        .issue_master_inst(issue_master_inst), .issue_master_pc(issue_master_pc),
        .issue_slave_valid(issue_slave_valid), .issue_slave_inst(issue_slave_inst),
        .issue_slave_pc(issue_slave_pc), .slave_in_delayslot(slave_in_delayslot)
    );

    always #20 clk = ~clk;  // 40 ns period.

    initial begin
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;
    end

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("mismatch at %0t: %s is %b, expected %b", $time, name, actual, expected);
            $display("sim failed");
            $fatal(1, "wrong value on %s", name);
        end
    endtask

    task automatic check_inst(input string name, input mips_isa_pkg::inst_t actual,
                              input mips_isa_pkg::inst_t expected);
        if (actual !== expected) begin
            $display("mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
            $display("sim failed");
            $fatal(1, "wrong value on %s", name);
        end
    endtask

    task automatic check_pc(input string name, input issue_pkg::pc_t actual,
                            input issue_pkg::pc_t expected);
        if (actual !== expected) begin
            $display("mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
            $display("sim failed");
            $fatal(1, "wrong value on %s", name);
        end
    endtask

    // hazard-relevant fields of one instruction word
    function automatic dec_t decode(input mips_isa_pkg::inst_t inst);
        dec_t                  d;
        mips_isa_pkg::opcode_t op;
        mips_isa_pkg::funct_t  fn;
        d  = '0;
        op = inst[31:26];
        fn = inst[5:0];
        if (op == mips_isa_pkg::SPECIAL) begin
            if (fn == mips_isa_pkg::ADDU || fn == mips_isa_pkg::SUBU ||
                fn == mips_isa_pkg::OR) begin
                d.wen   = 1'b1;
                d.waddr = inst[15:11];
            end else if (fn == mips_isa_pkg::JR) begin
                d.branch = 1'b1;
            end else if (fn == mips_isa_pkg::MULT || fn == mips_isa_pkg::DIV) begin
                d.master_only = 1'b1;
            end else begin
                d.spec = 1'b1;  // syscall and unknown functions.
            end
        end else if (op == mips_isa_pkg::J || op == mips_isa_pkg::BEQ ||
                     op == mips_isa_pkg::BNE) begin
            d.branch = 1'b1;
        end else if (op == mips_isa_pkg::JAL) begin
            d.branch = 1'b1;
            d.wen    = 1'b1;
            d.waddr  = mips_isa_pkg::REG_RA;
        end else if (op == mips_isa_pkg::ADDIU || op == mips_isa_pkg::ORI ||
                     op == mips_isa_pkg::LUI || op == mips_isa_pkg::LW) begin
            d.wen   = 1'b1;
            d.waddr = inst[20:16];
            d.mem   = (op == mips_isa_pkg::LW);
            d.load  = (op == mips_isa_pkg::LW);
        end else if (op == mips_isa_pkg::SW) begin
            d.mem = 1'b1;
        end else if (op == mips_isa_pkg::COP0) begin
            d.master_only = 1'b1;
            d.wen         = (inst[25:21] == mips_isa_pkg::COP0_MF);  // mfc0 writes rt.
            d.waddr       = d.wen ? inst[20:16] : '0;
        end else begin
            d.spec = 1'b1;
        end
        return d;
    endfunction

    function automatic logic load_hit(input logic load, input mips_isa_pkg::reg_addr_t waddr,
                                      input mips_isa_pkg::reg_addr_t rs,
                                      input mips_isa_pkg::reg_addr_t rt);
        return load && (waddr != '0) && (rs == waddr || rt == waddr);
    endfunction

    function automatic mips_isa_pkg::reg_addr_t pick_reg();
        return mips_isa_pkg::reg_addr_t'($unsigned($random(seed)) % 5);  // r0..r4.
    endfunction

    // weighted mix, alu and loads dominate
    function automatic mips_isa_pkg::inst_t random_inst();
        mips_isa_pkg::inst_t     inst;
        mips_isa_pkg::reg_addr_t ra;
        mips_isa_pkg::reg_addr_t rb;
        mips_isa_pkg::reg_addr_t rc;
        logic [15:0]             imm;
        int                      kind;
        kind = int'($unsigned($random(seed)) % 20);
        ra   = pick_reg();
        rb   = pick_reg();
        rc   = pick_reg();
        imm  = 16'($random(seed));
        if (kind < 5) inst = {mips_isa_pkg::SPECIAL, ra, rb, rc, 5'd0, mips_isa_pkg::ADDU};
        else if (kind < 8) inst = {mips_isa_pkg::ADDIU, ra, rb, imm};
        else if (kind < 12) inst = {mips_isa_pkg::LW, ra, rb, imm};
        else if (kind < 14) inst = {mips_isa_pkg::SW, ra, rb, imm};
        else if (kind == 14) inst = {mips_isa_pkg::BEQ, ra, rb, imm};
        else if (kind == 15) inst = {mips_isa_pkg::JAL, ra, rb, imm};
        else if (kind == 16) inst = {mips_isa_pkg::SPECIAL, ra, 15'd0, mips_isa_pkg::JR};
        else if (kind == 17) inst = {mips_isa_pkg::SPECIAL, 20'd0, mips_isa_pkg::SYSCALL};
        else if (kind == 18) inst = {mips_isa_pkg::SPECIAL, ra, rb, 10'd0, mips_isa_pkg::MULT};
        else inst = {mips_isa_pkg::COP0, mips_isa_pkg::COP0_MT, rb, rc, 11'd0};  // mtc0.
        return inst;
    endfunction

    // one clock cycle: drive, check against the model, advance the model
    task automatic run_cycle(input logic may_push, input logic may_stall);
        dec_t                    md;
        dec_t                    sd;
        mips_isa_pkg::inst_t     head;
        mips_isa_pkg::inst_t     next;
        int                      cnt;
        logic                    exp_m;
        logic                    exp_s;
        logic                    blocked;
        @(posedge clk);
        #2;
        cnt         = q_inst.size();
        fetch_push  = may_push && (depth - cnt >= 2) && ($unsigned($random(seed)) % 100 < 60);
        fetch_inst0 = random_inst();
        fetch_inst1 = random_inst();
        fetch_pc    = next_fetch_pc;
        stall       = may_stall && ($unsigned($random(seed)) % 100 < 15);
        #34;  // just before the next edge.
        md    = '0;
        sd    = '0;
        exp_m = 1'b0;
        exp_s = 1'b0;
        if (cnt > 0) begin
            head  = q_inst[0];
            md    = decode(head);
            exp_m = !stall && !load_hit(em_load, em_waddr, head[25:21], head[20:16]) &&
                    !load_hit(es_load, es_waddr, head[25:21], head[20:16]);
        end
        if (exp_m && cnt >= 2) begin
            next    = q_inst[1];
            sd      = decode(next);
            blocked = load_hit(em_load, em_waddr, next[25:21], next[20:16]) ||
                      load_hit(es_load, es_waddr, next[25:21], next[20:16]) ||
                      sd.branch || sd.spec || sd.master_only || md.spec || (md.mem && sd.mem) ||
                      (md.wen && md.waddr != '0 &&
                       (next[25:21] == '0 || next[20:16] == '0 ||
                        next[25:21] == md.waddr || next[20:16] == md.waddr));
            exp_s   = !blocked;
        end
        check_bit("queue_full", queue_full, (depth - cnt) < 2);
        check_bit("issue_master_valid", issue_master_valid, exp_m);
        check_bit("issue_slave_valid", issue_slave_valid, exp_s);
        check_bit("slave_in_delayslot", slave_in_delayslot, exp_s && md.branch);
        if (exp_m) begin
            check_inst("issue_master_inst", issue_master_inst, q_inst[0]);
            check_pc("issue_master_pc", issue_master_pc, q_pc[0]);
        end
        if (exp_s) begin
            check_inst("issue_slave_inst", issue_slave_inst, q_inst[1]);
            check_pc("issue_slave_pc", issue_slave_pc, q_pc[1]);
        end
        if (!stall) begin
            em_load  = exp_m && md.load;  // bubbles carry no load.
            em_waddr = exp_m ? md.waddr : '0;
            es_load  = exp_s && sd.load;
            es_waddr = exp_s ? sd.waddr : '0;
        end
        if (exp_m) begin
            void'(q_inst.pop_front());
            void'(q_pc.pop_front());
        end
        if (exp_s) begin
            void'(q_inst.pop_front());
            void'(q_pc.pop_front());
        end
        if (fetch_push) begin
            q_inst.push_back(fetch_inst0);
            q_pc.push_back(fetch_pc);
            q_inst.push_back(fetch_inst1);
            q_pc.push_back(fetch_pc + 32'd4);
            next_fetch_pc = next_fetch_pc + 32'd8;
        end
    endtask

    initial begin
        int waited;
        int i;
        waited = 0;
        while (rst) begin
            @(posedge clk);
            #10;
            waited++;
            if (waited > 40) begin
                $display("sim failed");
                $fatal(1, "reset was not released within 40 cycles");
            end
        end
        #26;
        check_bit("queue_full", queue_full, 1'b0);
        check_bit("issue_master_valid", issue_master_valid, 1'b0);
        check_bit("issue_slave_valid", issue_slave_valid, 1'b0);
        check_bit("slave_in_delayslot", slave_in_delayslot, 1'b0);
        for (i = 0; i < run_cycles; i++) begin
            run_cycle(1'b1, 1'b1);
        end
        waited = 0;
        while (q_inst.size() != 0) begin  // drain without push or stall.
            run_cycle(1'b0, 1'b0);
            waited++;
            if (waited > 200) begin
                $display("sim failed");
                $fatal(1, "queue did not drain within 200 cycles");
            end
        end
        $display("sim passed");
        $finish;
    end

endmodule

// ==== dual_issue_stage.sv ====
`timescale 1ns/10ps

module dual_issue_stage #(
    parameter int queue_depth = issue_pkg::QUEUE_DEPTH_DEFAULT
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                fetch_push,
    input  mips_isa_pkg::inst_t fetch_inst0,
    input  mips_isa_pkg::inst_t fetch_inst1,
    input  issue_pkg::pc_t      fetch_pc,
    input  logic                stall,
    output logic                queue_full,
    output logic                issue_master_valid,
    output mips_isa_pkg::inst_t issue_master_inst,
    output issue_pkg::pc_t      issue_master_pc,
    output logic                issue_slave_valid,
    output mips_isa_pkg::inst_t issue_slave_inst,
    output issue_pkg::pc_t      issue_slave_pc,
    output logic                slave_in_delayslot
);

    logic                    queue_empty;
    logic                    queue_almost_empty;

    mips_isa_pkg::reg_addr_t m_rs;
    mips_isa_pkg::reg_addr_t m_rt;
    logic                    m_reg_wen;
    mips_isa_pkg::reg_addr_t m_reg_waddr;
    logic                    m_mem_en;
    logic                    m_mem_to_reg;
    logic                    m_is_branch;
    logic                    m_is_spec_inst;

    mips_isa_pkg::opcode_t   s_op;
    mips_isa_pkg::reg_addr_t s_rs;
    mips_isa_pkg::reg_addr_t s_rt;
    mips_isa_pkg::reg_addr_t s_reg_waddr;
    logic                    s_mem_en;
    logic                    s_mem_to_reg;
    logic                    s_is_branch;
    logic                    s_is_spec_inst;
    logic                    s_is_only_in_master;

    logic                    e_master_mem_to_reg;
    mips_isa_pkg::reg_addr_t e_master_reg_waddr;
    logic                    e_slave_mem_to_reg;
    mips_isa_pkg::reg_addr_t e_slave_reg_waddr;

    inst_queue #(.queue_depth(queue_depth)) i_inst_queue (
        .clk(clk), .rst(rst),
        .push(fetch_push), .push_inst0(fetch_inst0), .push_inst1(fetch_inst1),
        .push_pc(fetch_pc),
        .pop_one(issue_master_valid), .pop_two(issue_slave_valid),
        .head_inst(issue_master_inst), .head_pc(issue_master_pc),
        .next_inst(issue_slave_inst), .next_pc(issue_slave_pc),
        .empty(queue_empty), .almost_empty(queue_almost_empty), .full(queue_full)
    );

    inst_decoder i_master_decoder (
        .inst(issue_master_inst), .op(), .rs(m_rs), .rt(m_rt),
        .reg_wen(m_reg_wen), .reg_waddr(m_reg_waddr),
        .mem_en(m_mem_en), .mem_to_reg(m_mem_to_reg),
        .is_branch(m_is_branch), .is_spec_inst(m_is_spec_inst), .is_only_in_master()
    );

    inst_decoder i_slave_decoder (
        .inst(issue_slave_inst), .op(s_op), .rs(s_rs), .rt(s_rt),
        .reg_wen(), .reg_waddr(s_reg_waddr),
        .mem_en(s_mem_en), .mem_to_reg(s_mem_to_reg),
        .is_branch(s_is_branch), .is_spec_inst(s_is_spec_inst),
        .is_only_in_master(s_is_only_in_master)
    );

    issue_ctrl i_issue_ctrl (
        .master_en(issue_master_valid), .master_reg_wen(m_reg_wen),
        .master_mem_en(m_mem_en), .master_reg_waddr(m_reg_waddr),
        .master_is_branch(m_is_branch), .master_is_spec_inst(m_is_spec_inst),
        .e_master_mem_to_reg(e_master_mem_to_reg), .e_master_reg_waddr(e_master_reg_waddr),
        .e_slave_mem_to_reg(e_slave_mem_to_reg), .e_slave_reg_waddr(e_slave_reg_waddr),
        .slave_op(s_op), .slave_rs(s_rs), .slave_rt(s_rt), .slave_mem_en(s_mem_en),
        .slave_is_branch(s_is_branch), .slave_is_spec_inst(s_is_spec_inst),
        .slave_is_only_in_master(s_is_only_in_master),
        .fifo_empty(queue_empty), .fifo_almost_empty(queue_almost_empty),
        .slave_in_delayslot(slave_in_delayslot), .slave_en(issue_slave_valid)
    );

    exec_stage_reg i_exec_stage_reg (
        .clk(clk), .rst(rst), .stall(stall), .queue_empty(queue_empty),
        .master_rs(m_rs), .master_rt(m_rt),
        .master_mem_to_reg(m_mem_to_reg), .master_reg_waddr(m_reg_waddr),
        .slave_en(issue_slave_valid), .slave_mem_to_reg(s_mem_to_reg),
        .slave_reg_waddr(s_reg_waddr), .master_en(issue_master_valid),
        .e_master_mem_to_reg(e_master_mem_to_reg), .e_master_reg_waddr(e_master_reg_waddr),
        .e_slave_mem_to_reg(e_slave_mem_to_reg), .e_slave_reg_waddr(e_slave_reg_waddr)
    );

endmodule

// ==== exec_stage_reg.sv ====
`timescale 1ns/10ps

module exec_stage_reg (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    stall,
    input  logic                    queue_empty,
    input  mips_isa_pkg::reg_addr_t master_rs,
    input  mips_isa_pkg::reg_addr_t master_rt,
    input  logic                    master_mem_to_reg,
    input  mips_isa_pkg::reg_addr_t master_reg_waddr,
    input  logic                    slave_en,
    input  logic                    slave_mem_to_reg,
    input  mips_isa_pkg::reg_addr_t slave_reg_waddr,
    output logic                    master_en,
    output logic                    e_master_mem_to_reg,
    output mips_isa_pkg::reg_addr_t e_master_reg_waddr,
    output logic                    e_slave_mem_to_reg,
    output mips_isa_pkg::reg_addr_t e_slave_reg_waddr
);

    logic hit_e_master;
    logic hit_e_slave;
    logic load_use;

    // a load in execute whose result the master reads
    assign hit_e_master = e_master_mem_to_reg & (e_master_reg_waddr != '0) &
                          ((master_rs == e_master_reg_waddr) |
                           (master_rt == e_master_reg_waddr));
    assign hit_e_slave  = e_slave_mem_to_reg & (e_slave_reg_waddr != '0) &
                          ((master_rs == e_slave_reg_waddr) |
                           (master_rt == e_slave_reg_waddr));
    assign load_use = hit_e_master | hit_e_slave;

    assign master_en = !queue_empty & !stall & !load_use;

    always_ff @(posedge clk) begin
        if (rst) begin
            e_master_mem_to_reg <= 1'b0;
            e_master_reg_waddr  <= '0;
            e_slave_mem_to_reg  <= 1'b0;
            e_slave_reg_waddr   <= '0;
        end else if (!stall) begin
            // slots that did not issue become bubbles
            e_master_mem_to_reg <= master_en & master_mem_to_reg;
            e_master_reg_waddr  <= master_en ? master_reg_waddr : '0;
            e_slave_mem_to_reg  <= slave_en & slave_mem_to_reg;
            e_slave_reg_waddr   <= slave_en ? slave_reg_waddr : '0;
        end
    end

    // the bubble clears the hazard, so a load-use stall lasts one cycle
    a_load_use_once : assert property (@(posedge clk) disable iff (rst)
        (!queue_empty && !stall && !master_en) |=> (stall || master_en))
        else $error("exec_stage_reg: load-use stall held for more than one cycle.");

endmodule

// ==== issue_ctrl.sv ====
`timescale 1ns/10ps

module issue_ctrl (
    // master status
    input  logic                    master_en,
    input  logic                    master_reg_wen,
    input  logic                    master_mem_en,
    input  mips_isa_pkg::reg_addr_t master_reg_waddr,
    input  logic                    master_is_branch,
    input  logic                    master_is_spec_inst,
    // execute stage status
    input  logic                    e_master_mem_to_reg,
    input  mips_isa_pkg::reg_addr_t e_master_reg_waddr,
    input  logic                    e_slave_mem_to_reg,
    input  mips_isa_pkg::reg_addr_t e_slave_reg_waddr,
    // slave status
    input  mips_isa_pkg::opcode_t   slave_op,
    input  mips_isa_pkg::reg_addr_t slave_rs,
    input  mips_isa_pkg::reg_addr_t slave_rt,
    input  logic                    slave_mem_en,
    input  logic                    slave_is_branch,
    input  logic                    slave_is_spec_inst,
    input  logic                    slave_is_only_in_master,
    // queue status
    input  logic                    fifo_empty,
    input  logic                    fifo_almost_empty,
    output logic                    slave_in_delayslot,
    output logic                    slave_en
);

    logic fifo_disable;
    logic struct_conflict;
    logic load_stall;
    logic master_dep;

    assign fifo_disable    = fifo_empty | fifo_almost_empty;  // need two entries.
    assign struct_conflict = master_mem_en & slave_mem_en;     // one memory port.

    assign load_stall =
        (e_master_mem_to_reg & (((|slave_rs) & (slave_rs == e_master_reg_waddr)) |
                                ((|slave_rt) & (slave_rt == e_master_reg_waddr)))) |
        (e_slave_mem_to_reg  & (((|slave_rs) & (slave_rs == e_slave_reg_waddr)) |
                                ((|slave_rt) & (slave_rt == e_slave_reg_waddr))));

    // a slave reading r0 is held back too while the master writes a register
    assign master_dep = master_reg_wen & (master_reg_waddr != '0) &
                        !(((|slave_rs) & (slave_rs != master_reg_waddr)) &&
                          ((|slave_rt) & (slave_rt != master_reg_waddr)));

    always_comb begin
        if (!master_en || fifo_disable || load_stall || slave_is_branch ||
            master_is_spec_inst || slave_is_spec_inst || slave_is_only_in_master ||
            struct_conflict) begin
            slave_en = 1'b0;
        end else begin
            slave_en = !master_dep;
        end

        // decoder must flag every cp0 op as master only
        a_slave_legal : assert (!slave_en ||
                                (master_en && (slave_op != mips_isa_pkg::COP0)))
            else $error("issue_ctrl: illegal slave issue.");
    end

    assign slave_in_delayslot = master_is_branch & slave_en;  // slave fills the delay slot.

endmodule

// ==== inst_decoder.sv ====
`timescale 1ns/10ps

module inst_decoder (
    input  mips_isa_pkg::inst_t     inst,
    output mips_isa_pkg::opcode_t   op,
    output mips_isa_pkg::reg_addr_t rs,
    output mips_isa_pkg::reg_addr_t rt,
    output logic                    reg_wen,
    output mips_isa_pkg::reg_addr_t reg_waddr,
    output logic                    mem_en,
    output logic                    mem_to_reg,
    output logic                    is_branch,
    output logic                    is_spec_inst,
    output logic                    is_only_in_master
);

    mips_isa_pkg::funct_t    funct;
    mips_isa_pkg::reg_addr_t rd;

    assign op    = inst[31:26];
    assign rs    = inst[25:21];
    assign rt    = inst[20:16];
    assign rd    = inst[15:11];
    assign funct = inst[5:0];

    always_comb begin
        reg_wen           = 1'b0;
        reg_waddr         = '0;   // no destination by default.
        mem_en            = 1'b0;
        mem_to_reg        = 1'b0;
        is_branch         = 1'b0;
        is_spec_inst      = 1'b0;
        is_only_in_master = 1'b0;

        case (op)
            mips_isa_pkg::SPECIAL: begin
                case (funct)
                    mips_isa_pkg::ADDU,
                    mips_isa_pkg::SUBU,
                    mips_isa_pkg::OR: begin
                        reg_wen   = 1'b1;
                        reg_waddr = rd;  // r-type writes rd.
                    end
                    mips_isa_pkg::JR: begin
                        is_branch = 1'b1;
                    end
                    mips_isa_pkg::SYSCALL: begin
                        is_spec_inst = 1'b1;
                    end
                    mips_isa_pkg::MULT,
                    mips_isa_pkg::DIV: begin
                        is_only_in_master = 1'b1;  // single hi/lo unit.
                    end
                    default: begin
                        is_spec_inst = 1'b1;  // unknown, issue alone.
                    end
                endcase
            end
            mips_isa_pkg::J,
            mips_isa_pkg::BEQ,
            mips_isa_pkg::BNE: begin
                is_branch = 1'b1;
            end
            mips_isa_pkg::JAL: begin
                is_branch = 1'b1;
                reg_wen   = 1'b1;
                reg_waddr = mips_isa_pkg::REG_RA;
            end
            mips_isa_pkg::ADDIU,
            mips_isa_pkg::ORI,
            mips_isa_pkg::LUI: begin
                reg_wen   = 1'b1;
                reg_waddr = rt;  // immediate forms write rt.
            end
            mips_isa_pkg::LW: begin
                reg_wen    = 1'b1;
                reg_waddr  = rt;
                mem_en     = 1'b1;
                mem_to_reg = 1'b1;
            end
            mips_isa_pkg::SW: begin
                mem_en = 1'b1;
            end
            mips_isa_pkg::COP0: begin
                is_only_in_master = 1'b1;  // cp0 lives next to the master pipe.
                if (rs == mips_isa_pkg::COP0_MF) begin
                    reg_wen   = 1'b1;
                    reg_waddr = rt;
                end
            end
            default: begin
                is_spec_inst = 1'b1;
            end
        endcase
    end

endmodule

// ==== inst_queue.sv ====
`timescale 1ns/10ps

module inst_queue #(
    parameter int queue_depth = issue_pkg::QUEUE_DEPTH_DEFAULT
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                push,
    input  mips_isa_pkg::inst_t push_inst0,
    input  mips_isa_pkg::inst_t push_inst1,
    input  issue_pkg::pc_t      push_pc,
    input  logic                pop_one,
    input  logic                pop_two,
    output mips_isa_pkg::inst_t head_inst,
    output issue_pkg::pc_t      head_pc,
    output mips_isa_pkg::inst_t next_inst,
    output issue_pkg::pc_t      next_pc,
    output logic                empty,
    output logic                almost_empty,
    output logic                full
);

    localparam int ptr_w = $clog2(queue_depth);

    mips_isa_pkg::inst_t inst_mem [queue_depth];
    issue_pkg::pc_t      pc_mem   [queue_depth];

    logic [ptr_w-1:0]    rd_ptr;
    logic [ptr_w-1:0]    rd_ptr_1;
    logic [ptr_w-1:0]    wr_ptr;
    logic [ptr_w-1:0]    wr_ptr_1;
    issue_pkg::q_count_t count;
    issue_pkg::q_count_t push_n;
    issue_pkg::q_count_t pop_n;
    logic                push_ok;

    assign push_ok  = push & ~full;  // a push against a full queue is dropped.
    assign rd_ptr_1 = rd_ptr + ptr_w'(1);  // pointers wrap, depth is a power of two.
    assign wr_ptr_1 = wr_ptr + ptr_w'(1);

    assign push_n = push_ok ? issue_pkg::q_count_t'(issue_pkg::PUSH_WIDTH) : '0;
    assign pop_n  = pop_two ? issue_pkg::q_count_t'(2) :
                    pop_one ? issue_pkg::q_count_t'(1) : '0;

    // pair storage
    always_ff @(posedge clk) begin
        if (push_ok) begin
            inst_mem[wr_ptr]   <= push_inst0;
            pc_mem[wr_ptr]     <= push_pc;
            inst_mem[wr_ptr_1] <= push_inst1;
            pc_mem[wr_ptr_1]   <= push_pc + issue_pkg::PC_STEP;  // second word of the pair.
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + ptr_w'(issue_pkg::PUSH_WIDTH);
            end
            if (pop_two) begin
                rd_ptr <= rd_ptr + ptr_w'(2);
            end else if (pop_one) begin
                rd_ptr <= rd_ptr_1;
            end
            count <= count + push_n - pop_n;
        end
    end

    assign head_inst = inst_mem[rd_ptr];    // master candidate.
    assign head_pc   = pc_mem[rd_ptr];
    assign next_inst = inst_mem[rd_ptr_1];  // slave candidate.
    assign next_pc   = pc_mem[rd_ptr_1];

    assign empty        = (count == '0);
    assign almost_empty = (count == issue_pkg::q_count_t'(1));
    // full as soon as a whole pair no longer fits
    assign full = (issue_pkg::q_count_t'(queue_depth) - count) <
                  issue_pkg::q_count_t'(issue_pkg::PUSH_WIDTH);

    a_no_push_full : assert property (@(posedge clk) disable iff (rst) !(push && full))
        else $error("inst_queue: push while full.");

    a_pop_two_count : assert property (@(posedge clk) disable iff (rst)
        pop_two |-> (count >= issue_pkg::q_count_t'(2)))
        else $error("inst_queue: pop of two with fewer than two entries.");

endmodule

// ==== issue_pkg.sv ====
package issue_pkg;

    typedef logic [31:0] pc_t;  // program counter of a queue entry.

    // occupancy counter width, covers depths up to 128 entries
    localparam int COUNT_W = 8;

    typedef logic [COUNT_W-1:0] q_count_t;  // number of valid queue entries.

    // default instruction queue depth, power of two and at least 4
    localparam int QUEUE_DEPTH_DEFAULT = 8;

    // fetch always delivers an aligned pair
    localparam int PUSH_WIDTH = 2;

    // byte distance between the two words of a pair
    localparam pc_t PC_STEP = 32'd4;

endpackage

// ==== mips_isa_pkg.sv ====
package mips_isa_pkg;

    typedef logic [31:0] inst_t;      // raw instruction word.
    typedef logic [4:0]  reg_addr_t;  // gpr number, r0 is hard wired.
    typedef logic [5:0]  opcode_t;    // primary opcode field.
    typedef logic [5:0]  funct_t;     // function field of SPECIAL.

    // primary opcodes of the decoded subset
    localparam opcode_t SPECIAL = 6'h00;
    localparam opcode_t J       = 6'h02;
    localparam opcode_t JAL     = 6'h03;
    localparam opcode_t BEQ     = 6'h04;
    localparam opcode_t BNE     = 6'h05;
    localparam opcode_t ADDIU   = 6'h09;
    localparam opcode_t ORI     = 6'h0d;
    localparam opcode_t LUI     = 6'h0f;
    localparam opcode_t COP0    = 6'h10;
    localparam opcode_t LW      = 6'h23;
    localparam opcode_t SW      = 6'h2b;

    // function codes under SPECIAL
    localparam funct_t JR      = 6'h08;
    localparam funct_t SYSCALL = 6'h0c;
    localparam funct_t MULT    = 6'h18;
    localparam funct_t DIV     = 6'h1a;
    localparam funct_t ADDU    = 6'h21;
    localparam funct_t SUBU    = 6'h23;
    localparam funct_t OR      = 6'h25;

    // rs field of COP0 moves
    localparam reg_addr_t COP0_MF = 5'b00000;  // mfc0, writes gpr rt.
    localparam reg_addr_t COP0_MT = 5'b00100;  // mtc0, reads gpr rt.

    localparam reg_addr_t REG_RA = 5'd31;      // link register of jal.

endpackage
